//--- rtl/disp_consts.svh
// ----------------------------------------------------------
// Sizing constants for the disparity search engine
// Included by the package and by every RTL file that sizes
// ports or counters from them
// ----------------------------------------------------------
`ifndef DISP_CONSTS_SVH
`define DISP_CONSTS_SVH

// Window side, in pixels
`define DISP_WIN 3
`define DISP_PIX_W 8
// Number of disparities searched
`define DISP_MAX 8

// Right strip columns, WIN + MAX - 1
`define DISP_SPAN (`DISP_WIN + `DISP_MAX - 1)

// Holds WIN*WIN*255 without overflow
`define DISP_SAD_W 12
`define DISP_IDX_W 3
// Wide enough for both the preload count and the strip column
`define DISP_CNT_W 4

`endif

//--- rtl/disp_pkg.sv
// ----------------------------------------------------------
// Shared types of the disparity search engine
// Pixel, SAD and disparity types plus the search FSM states
// ----------------------------------------------------------
`include "disp_consts.svh"

package disp_pkg;

    typedef logic [`DISP_PIX_W-1:0] pixel_t;

    typedef logic [`DISP_SAD_W-1:0] sad_t;

    typedef logic [`DISP_IDX_W-1:0] disp_t;

    // Search sequence, one state per phase
    typedef enum logic [2:0] {
        IDLE,
        PRELOAD,
        COMPUTE,
        COMPARE,
        DONE
    } search_state_t;

endpackage

//--- rtl/search_ctrl_if.sv
// ----------------------------------------------------------
// Control and status bundle between the search FSM, the
// counters, the window shifter and the best-match registers
// ----------------------------------------------------------
`include "disp_consts.svh"

interface search_ctrl_if;
    import disp_pkg::*;

    // Enables from the FSM
    logic preload_en;
    logic slide_en;
    logic capture_l;
    logic clear_best;
    logic compare_en;

    // Counter status
    logic [`DISP_CNT_W-1:0] col_idx;
    disp_t disp_idx;
    logic preload_last;
    logic disp_last;

    // Match status
    logic zero_hit;

    modport fsm (
        output preload_en, slide_en, capture_l, clear_best, compare_en,
        input preload_last, disp_last, zero_hit
    );

    modport counter (
        input preload_en, slide_en, clear_best,
        output col_idx, disp_idx, preload_last, disp_last
    );

    modport window (input capture_l, preload_en, slide_en, col_idx);

    modport match (input clear_best, compare_en, disp_idx, output zero_hit);

endinterface

//--- rtl/search_fsm.sv
// ----------------------------------------------------------
// Search sequencer: start, WIN preload cycles, then one
// COMPUTE and one COMPARE cycle per disparity until done
// ----------------------------------------------------------
module search_fsm (
    input logic clk,
    input logic rst,
    search_ctrl_if.fsm ctrl,
    input logic start,
    output logic done,
    output logic busy,
    output disp_pkg::search_state_t state
);
    import disp_pkg::*;

    search_state_t next_state;
    logic start_ok;

    // A start is honoured only when no search is running
    assign start_ok = start && (state == IDLE || state == DONE);

    assign ctrl.capture_l = start_ok;
    assign ctrl.clear_best = start_ok;
    assign ctrl.preload_en = (state == PRELOAD);
    assign ctrl.compare_en = (state == COMPARE);
    // Slide only when this compare continues the search
    assign ctrl.slide_en = ctrl.compare_en && !ctrl.disp_last && !ctrl.zero_hit;

    assign done = (state == DONE);
    assign busy = (state == PRELOAD || state == COMPUTE || state == COMPARE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, DONE: begin
                if (start) begin
                    next_state = PRELOAD;
                end
            end
            PRELOAD: begin
                if (ctrl.preload_last) begin
                    next_state = COMPUTE;
                end
            end
            // SAD settles here
            COMPUTE: next_state = COMPARE;
            COMPARE: begin
                if (ctrl.disp_last || ctrl.zero_hit) begin
                    next_state = DONE;
                end else begin
                    next_state = COMPUTE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Every compare follows a full settle cycle
    a_compare_after_compute: assert property (
        @(posedge clk) disable iff (rst)
        ctrl.compare_en |-> ($past(state) == COMPUTE)
    );

endmodule

//--- rtl/disp_counter.sv
// ----------------------------------------------------------
// Strip column and disparity counters
// col_idx doubles as the preload count, then tracks the next
// strip column to slide in; both clear on a new start
// ----------------------------------------------------------
`include "disp_consts.svh"

module disp_counter (
    input logic clk,
    input logic rst,
    search_ctrl_if.counter ctrl
);
    import disp_pkg::*;

    localparam logic [`DISP_CNT_W-1:0] PRE_LAST = `DISP_CNT_W'(`DISP_WIN - 1);
    localparam disp_t DISP_END = disp_t'(`DISP_MAX - 1);

    // Final preload column is on the bus this cycle
    assign ctrl.preload_last = ctrl.preload_en && (ctrl.col_idx == PRE_LAST);
    assign ctrl.disp_last = (ctrl.disp_idx == DISP_END);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl.col_idx <= '0;
            ctrl.disp_idx <= '0;
        end else if (ctrl.clear_best) begin
            ctrl.col_idx <= '0;
            ctrl.disp_idx <= '0;
        end else begin
            if (ctrl.preload_en || ctrl.slide_en) begin
                ctrl.col_idx <= ctrl.col_idx + 1'b1;
            end
            if (ctrl.slide_en) begin
                ctrl.disp_idx <= ctrl.disp_idx + 1'b1;
            end
        end
    end

    // Past preload the strip column runs WIN ahead of the disparity
    a_disp_tracks_col: assert property (
        @(posedge clk) disable iff (rst)
        (!ctrl.preload_en && ctrl.col_idx != '0)
            |-> (int'(ctrl.col_idx) == int'(ctrl.disp_idx) + `DISP_WIN)
    );

    // Any column fetched lies inside the strip
    a_col_in_strip: assert property (
        @(posedge clk) disable iff (rst)
        (ctrl.preload_en || ctrl.slide_en) |-> (ctrl.col_idx < `DISP_SPAN)
    );

endmodule

//--- rtl/window_shifter.sv
// ----------------------------------------------------------
// Left window latch and right window shift register
// Each load shifts every right row one place left and
// appends strip column col_idx at the right edge
// ----------------------------------------------------------
`include "disp_consts.svh"

module window_shifter (
    input logic clk,
    input logic rst,
    search_ctrl_if.window ctrl,
    input disp_pkg::pixel_t win_l [`DISP_WIN][`DISP_WIN],
    input disp_pkg::pixel_t strip_r [`DISP_WIN][`DISP_SPAN],
    output disp_pkg::pixel_t win_l_q [`DISP_WIN][`DISP_WIN],
    output disp_pkg::pixel_t win_r_q [`DISP_WIN][`DISP_WIN]
);
    import disp_pkg::*;

    logic load_col;

    // Preload and slide both pull in one strip column
    assign load_col = ctrl.preload_en || ctrl.slide_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `DISP_WIN; r++) begin
                for (int c = 0; c < `DISP_WIN; c++) begin
                    win_l_q[r][c] <= '0;
                    win_r_q[r][c] <= '0;
                end
            end
        end else begin
            if (ctrl.capture_l) begin
                win_l_q <= win_l;
            end
            if (load_col) begin
                for (int r = 0; r < `DISP_WIN; r++) begin
                    for (int c = 0; c < `DISP_WIN - 1; c++) begin
                        win_r_q[r][c] <= win_r_q[r][c + 1];
                    end
                    // New column enters on the right
                    win_r_q[r][`DISP_WIN - 1] <= strip_r[r][ctrl.col_idx];
                end
            end
        end
    end

endmodule

//--- rtl/sad_unit.sv
// ----------------------------------------------------------
// Sum of absolute differences over two WIN x WIN windows
// Purely combinational, settles within one COMPUTE cycle
// ----------------------------------------------------------
`include "disp_consts.svh"

module sad_unit (
    input disp_pkg::pixel_t win_l_q [`DISP_WIN][`DISP_WIN],
    input disp_pkg::pixel_t win_r_q [`DISP_WIN][`DISP_WIN],
    output disp_pkg::sad_t sad
);
    import disp_pkg::*;

    pixel_t diff [`DISP_WIN][`DISP_WIN];

    // Per-pixel absolute difference
    for (genvar r = 0; r < `DISP_WIN; r++) begin : g_row
        for (genvar c = 0; c < `DISP_WIN; c++) begin : g_col
            assign diff[r][c] = (win_l_q[r][c] >= win_r_q[r][c]) ?
                                (win_l_q[r][c] - win_r_q[r][c]) :
                                (win_r_q[r][c] - win_l_q[r][c]);
        end
    end

    always_comb begin
        sad = '0;
        for (int r = 0; r < `DISP_WIN; r++) begin
            for (int c = 0; c < `DISP_WIN; c++) begin
                sad = sad + sad_t'(diff[r][c]);
            end
        end
    end

endmodule

//--- rtl/best_match.sv
// ----------------------------------------------------------
// Best SAD and disparity registers
// Strictly smaller SAD wins, so ties keep the lower disparity;
// values hold after done until the next start clears them
// ----------------------------------------------------------
module best_match (
    input logic clk,
    input logic rst,
    search_ctrl_if.match ctrl,
    input disp_pkg::sad_t sad,
    output disp_pkg::disp_t disp,
    output disp_pkg::sad_t best_sad
);
    import disp_pkg::*;

    logic better;

    // Exact match ends the search early
    assign ctrl.zero_hit = (sad == '0);
    assign better = (sad < best_sad);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            best_sad <= '1;
            disp <= '0;
        end else if (ctrl.clear_best) begin
            best_sad <= '1;
            disp <= '0;
        end else if (ctrl.compare_en && better) begin
            best_sad <= sad;
            disp <= ctrl.disp_idx;
        end
    end

    // Clear comes from a start, which the FSM only takes outside COMPARE
    a_clear_not_compare: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.clear_best && ctrl.compare_en)
    );

endmodule

//--- rtl/disparity_search.sv
// ----------------------------------------------------------
// Top level of the per-pixel disparity search
// Pulse start with win_l and strip_r stable; result is valid
// while done is high and holds until the next start
// ----------------------------------------------------------
`include "disp_consts.svh"

module disparity_search (
    input logic clk,
    input logic rst,
    input logic start,
    input logic [`DISP_WIN*`DISP_WIN*`DISP_PIX_W-1:0] win_l,
    input logic [`DISP_WIN*`DISP_SPAN*`DISP_PIX_W-1:0] strip_r,
    output logic done,
    output logic busy,
    output disp_pkg::disp_t disp,
    output disp_pkg::sad_t best_sad
);
    import disp_pkg::*;

    pixel_t win_l_a [`DISP_WIN][`DISP_WIN];
    pixel_t strip_a [`DISP_WIN][`DISP_SPAN];
    pixel_t win_l_q [`DISP_WIN][`DISP_WIN];
    pixel_t win_r_q [`DISP_WIN][`DISP_WIN];
    sad_t sad;
    search_state_t fsm_state;

    search_ctrl_if ctrl ();

    // Flat buses are row major, pixel (r, c) at r*cols + c
    for (genvar r = 0; r < `DISP_WIN; r++) begin : g_row
        for (genvar c = 0; c < `DISP_WIN; c++) begin : g_win
            assign win_l_a[r][c] = win_l[`DISP_PIX_W*(r*`DISP_WIN + c) +: `DISP_PIX_W];
        end
        for (genvar c = 0; c < `DISP_SPAN; c++) begin : g_strip
            assign strip_a[r][c] = strip_r[`DISP_PIX_W*(r*`DISP_SPAN + c) +: `DISP_PIX_W];
        end
    end

    search_fsm u_fsm (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl.fsm),
        .start(start),
        .done(done),
        .busy(busy),
        .state(fsm_state)
    );

    disp_counter u_counter (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl.counter)
    );

    window_shifter u_window (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl.window),
        .win_l(win_l_a),
        .strip_r(strip_a),
        .win_l_q(win_l_q),
        .win_r_q(win_r_q)
    );

    sad_unit u_sad (
        .win_l_q(win_l_q),
        .win_r_q(win_r_q),
        .sad(sad)
    );

    best_match u_best (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl.match),
        .sad(sad),
        .disp(disp),
        .best_sad(best_sad)
    );

    // Start must have cleared the best registers before any compare
    a_preload_cleared: assert property (
        @(posedge clk) disable iff (rst)
        (fsm_state == PRELOAD) |-> (best_sad == '1)
    );

endmodule

//--- sim/tb_search_model.svh
// ----------------------------------------------------------
// Stimulus images, LCG and reference disparity search
// Included inside the testbench module body
// ----------------------------------------------------------
`ifndef TB_SEARCH_MODEL_SVH
`define TB_SEARCH_MODEL_SVH

// Row major images, same layout as the DUT buses
pixel_t left_pix [`DISP_WIN][`DISP_WIN];
pixel_t strip_pix [`DISP_WIN][`DISP_SPAN];
logic [31:0] lcg_state = 32'h5d8c_87e8;

function automatic pixel_t rand_pixel();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
endfunction

function automatic void fill_random();
    for (int r = 0; r < `DISP_WIN; r++) begin
        for (int c = 0; c < `DISP_WIN; c++) begin
            left_pix[r][c] = rand_pixel();
        end
        for (int c = 0; c < `DISP_SPAN; c++) begin
            strip_pix[r][c] = rand_pixel();
        end
    end
endfunction

function automatic void fill_const(input int lval, input int sval);
    for (int r = 0; r < `DISP_WIN; r++) begin
        for (int c = 0; c < `DISP_WIN; c++) begin
            left_pix[r][c] = pixel_t'(lval);
        end
        for (int c = 0; c < `DISP_SPAN; c++) begin
            strip_pix[r][c] = pixel_t'(sval);
        end
    end
endfunction

// Copy of the left window placed at strip column d
function automatic void plant_left(input int d);
    for (int r = 0; r < `DISP_WIN; r++) begin
        for (int c = 0; c < `DISP_WIN; c++) begin
            strip_pix[r][d + c] = left_pix[r][c];
        end
    end
endfunction

// Lowest SAD wins, ties keep the lower disparity, exact match stops early
function automatic void model_search(output int m_disp, output int m_sad, output int m_k);
    int sad;
    int a;
    int b;
    m_disp = 0;
    m_sad = (1 << `DISP_SAD_W) - 1;
    m_k = `DISP_MAX;
    for (int d = 0; d < `DISP_MAX; d++) begin
        sad = 0;
        for (int r = 0; r < `DISP_WIN; r++) begin
            for (int c = 0; c < `DISP_WIN; c++) begin
                a = int'(left_pix[r][c]);
                b = int'(strip_pix[r][d + c]);
                sad += (a > b) ? (a - b) : (b - a);
            end
        end
        if (sad < m_sad) begin
            m_sad = sad;
            m_disp = d;
        end
        if (sad == 0) begin
            m_k = d + 1;
            break;
        end
    end
endfunction

`endif

//--- sim/tb_disparity_search.sv
// ----------------------------------------------------------
// Testbench for the disparity search top level
// Runs random, planted and corner images through the DUT
// and checks every result with assertions against a model
// ----------------------------------------------------------
`include "disp_consts.svh"

module tb_disparity_search;
    timeunit 1ns;
    timeprecision 1ps;
    import disp_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int N_TESTS = 12;
    localparam int TEST_CYCLES = `DISP_WIN + 2 * `DISP_MAX + 20;

    logic clk;
    logic rst;
    logic start;
    logic [`DISP_WIN*`DISP_WIN*`DISP_PIX_W-1:0] win_l;
    logic [`DISP_WIN*`DISP_SPAN*`DISP_PIX_W-1:0] strip_r;
    logic done;
    logic busy;
    disp_t disp;
    sad_t best_sad;

    int value_errors = 0;
    int timing_errors = 0;
    int timeouts = 0;
    int tests_run = 0;
    int exp_disp = 0;
    int exp_sad = 0;
    int exp_k = 0;
    // Rising edges since the last start edge
    int cyc = 0;

    `include "tb_search_model.svh"

    disparity_search DUT (
        .clk(clk),
        .rst(rst),
        .start(start),
        .win_l(win_l),
        .strip_r(strip_r),
        .done(done),
        .busy(busy),
        .disp(disp),
        .best_sad(best_sad)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always_ff @(posedge clk) begin
        cyc <= start ? 0 : cyc + 1;
    end

    a_disp: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> (int'(disp) == exp_disp))
    else begin
        value_errors++;
        $display("error at %0t: disp %0d, expected %0d", $time, disp, exp_disp);
    end

    a_sad: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> (int'(best_sad) == exp_sad))
    else begin
        value_errors++;
        $display("error at %0t: best_sad %0d, expected %0d", $time, best_sad, exp_sad);
    end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> (cyc == `DISP_WIN + 2 * exp_k))
    else begin
        timing_errors++;
        $display("error at %0t: done after %0d cycles, expected %0d",
                 $time, cyc, `DISP_WIN + 2 * exp_k);
    end

    // A start from idle or done begins a new search at once
    a_busy_start: assert property (@(posedge clk) disable iff (rst)
        start |=> (busy && !done))
    else begin
        timing_errors++;
        $display("error at %0t: search did not restart on start", $time);
    end

    // busy may only drop into done
    a_busy_hold: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> done)
    else begin
        timing_errors++;
        $display("error at %0t: busy fell before done", $time);
    end

    // Result holds while done until the next start
    a_result_hold: assert property (@(posedge clk) disable iff (rst)
        (done && !start) |=> ($stable(disp) && $stable(best_sad)))
    else begin
        value_errors++;
        $display("error at %0t: result changed while done was high", $time);
    end

    function automatic void pack_inputs();
        for (int r = 0; r < `DISP_WIN; r++) begin
            for (int c = 0; c < `DISP_WIN; c++) begin
                win_l[`DISP_PIX_W*(r*`DISP_WIN + c) +: `DISP_PIX_W] = left_pix[r][c];
            end
            for (int c = 0; c < `DISP_SPAN; c++) begin
                strip_r[`DISP_PIX_W*(r*`DISP_SPAN + c) +: `DISP_PIX_W] = strip_pix[r][c];
            end
        end
    endfunction

    task automatic run_search(input string name);
        int m_disp;
        int m_sad;
        int m_k;
        int waited;
        model_search(m_disp, m_sad, m_k);
        @(negedge clk);
        exp_disp = m_disp;
        exp_sad = m_sad;
        exp_k = m_k;
        pack_inputs();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        waited = 0;
        while (!done && waited < TEST_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            timeouts++;
            $display("search %s never raised done", name);
        end
        // One more edge so the done checks fire
        @(negedge clk);
        tests_run++;
    endtask

    initial begin
        rst = 1'b1;
        start = 1'b0;
        win_l = '0;
        strip_r = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!done && !busy && disp == '0 && best_sad == '1)
        else begin
            value_errors++;
            $display("error at %0t: after reset done %0b busy %0b disp %0d best_sad %0d",
                     $time, done, busy, disp, best_sad);
        end

        for (int i = 0; i < 6; i++) begin
            fill_random();
            run_search("random");
        end

        // Exact copies end the search early
        fill_random();
        plant_left(0);
        run_search("planted 0");
        fill_random();
        plant_left(3);
        run_search("planted 3");
        fill_random();
        plant_left(7);
        run_search("planted 7");

        fill_random();
        plant_left(6);
        plant_left(2);
        run_search("twin");
        fill_const(40, 50);
        run_search("uniform");
        fill_const(255, 0);
        run_search("saturate");

        $display("tests %0d, value errors %0d, timing errors %0d, timeouts %0d",
                 tests_run, value_errors, timing_errors, timeouts);
        if (value_errors + timing_errors + timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + N_TESTS * TEST_CYCLES) @(posedge clk);
        $display("watchdog expired before all searches finished");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- compile.f
+incdir+rtl
+incdir+sim
rtl/disp_pkg.sv
rtl/search_ctrl_if.sv
rtl/search_fsm.sv
rtl/disp_counter.sv
rtl/window_shifter.sv
rtl/sad_unit.sv
rtl/best_match.sv
rtl/disparity_search.sv
sim/tb_disparity_search.sv

//--- Makefile
TOP = tb_disparity_search
RTL_TOP = disparity_search

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

lint:
	verilator --lint-only -Wall --timing --top-module $(RTL_TOP) -f compile.f

clean:
	rm -rf obj_dir
